//--- all.f
rtl/sdram_pkg.sv
rtl/sdram_timer.sv
rtl/sdram_sequencer.sv
rtl/sdram_datapath.sv
rtl/sdram_ctrl.sv
bench/sdram_chip_model.sv
bench/sdram_props.sv
bench/sdram_tb.sv

//--- bench/sdram_chip_model.sv
/*
 * behavioral SDRAM for simulation
 * decodes pin commands, keeps the open row per bank,
 * stores write beats and returns read beats after the CAS latency
 */
`default_nettype none

module sdram_chip_model (
    input  wire                                     clk,
    input  wire                                     cke,
    input  wire                                     cs_n,
    input  wire                                     ras_n,
    input  wire                                     cas_n,
    input  wire                                     we_n,
    input  wire  [sdram_pkg::bank_width-1:0]        ba,
    input  wire  [sdram_pkg::sdram_addr_width-1:0]  a,
    inout  wire  [sdram_pkg::sdram_data_width-1:0]  dq
);

    localparam int beat_width = sdram_pkg::sdram_data_width;
    localparam int key_width  =
        sdram_pkg::bank_width + sdram_pkg::row_width + sdram_pkg::col_width;
    // last pipeline stage of a read
    localparam int read_end   = sdram_pkg::cas_latency + sdram_pkg::burst_length - 1;

    logic [beat_width-1:0]              mem [logic [key_width-1:0]];
    logic [sdram_pkg::row_width-1:0]    open_row [1 << sdram_pkg::bank_width];
    logic [key_width-1:0]               rd_base;
    logic [key_width-1:0]               wr_base;
    logic [beat_width-1:0]              dq_out;
    logic                               dq_oe = 1'b0;
    sdram_pkg::cmd_t                    cmd;
    int                                 rd_stage = 0;
    int                                 wr_stage = 0;
    int                                 next_stage;

    assign cmd = sdram_pkg::cmd_t'({cs_n, ras_n, cas_n, we_n});
    assign dq  = dq_oe ? dq_out : 'z;

    // unwritten locations read as zero
    function automatic logic [beat_width-1:0] read_beat(input logic [key_width-1:0] key);
        if (mem.exists(key)) begin
            return mem[key];
        end
        return '0;
    endfunction

    always @(posedge clk) begin
        if (cke) begin
            // later write beats land on the following columns
            if (wr_stage != 0) begin
                mem[wr_base + key_width'(wr_stage)] = dq;
                wr_stage <= (wr_stage == sdram_pkg::burst_length - 1) ? 0 : wr_stage + 1;
            end

            // read pipeline, beats on the bus from stage cas_latency on
            if (rd_stage != 0) begin
                next_stage = (rd_stage == read_end) ? 0 : rd_stage + 1;
                rd_stage <= next_stage;
                dq_oe    <= (next_stage >= sdram_pkg::cas_latency);
                dq_out   <= read_beat(rd_base + key_width'(next_stage - sdram_pkg::cas_latency));
            end

            case (cmd)
                sdram_pkg::cmd_active: open_row[ba] <= a;
                sdram_pkg::cmd_write: begin
                    // first beat comes with the command
                    wr_base = {ba, open_row[ba], a[sdram_pkg::col_width-1:0]};
                    mem[wr_base] = dq;
                    wr_stage <= 1;
                end
                sdram_pkg::cmd_read: begin
                    rd_base  <= {ba, open_row[ba], a[sdram_pkg::col_width-1:0]};
                    rd_stage <= 1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- bench/sdram_props.sv
/*
 * pin protocol assertions for the SDRAM controller
 * single-cycle ack, data bus ownership during writes,
 * row cycle spacing and read-before-valid ordering
 */
`default_nettype none

module sdram_props #(
    parameter int active_wait         = 1,
    parameter int write_recovery_wait = 2
) (
    input wire       clk,
    input wire       reset,
    input wire       ack,
    input wire       valid,
    input wire       dq_oe,
    input wire [3:0] cmd
);

    localparam int active_gap  =
        active_wait + sdram_pkg::cas_latency + sdram_pkg::burst_length;
    localparam int quiet_after = active_gap - 1;
    localparam int write_beats = sdram_pkg::burst_length + write_recovery_wait;
    localparam int read_wait   = sdram_pkg::cas_latency + sdram_pkg::burst_length;

    logic active_cmd;
    logic read_cmd;
    logic write_cmd;
    int   write_age;
    int   failures = 0;

    assign active_cmd = (cmd == sdram_pkg::cmd_active);
    assign read_cmd   = (cmd == sdram_pkg::cmd_read);
    assign write_cmd  = (cmd == sdram_pkg::cmd_write);

    // cycles since the last write command, zero once its burst is over
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            write_age <= 0;
        end else if (write_cmd) begin
            write_age <= 1;
        end else if (write_age != 0 && write_age < write_beats - 1) begin
            write_age <= write_age + 1;
        end else begin
            write_age <= 0;
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else begin
            $error("ack held longer than one cycle");
            failures++;
        end

    // controller owns dq only inside a write burst
    dq_in_write: assert property (@(posedge clk) disable iff (reset)
        dq_oe |-> (write_cmd || write_age != 0))
        else begin
            $error("data bus driven outside a write burst");
            failures++;
        end

    active_spacing: assert property (@(posedge clk) disable iff (reset)
        active_cmd |=> (!active_cmd) [* quiet_after])
        else begin
            $error("two active commands too close together");
            failures++;
        end

    valid_after_read: assert property (@(posedge clk) disable iff (reset)
        valid |-> $past(read_cmd, read_wait))
        else begin
            $error("valid without a read command before it");
            failures++;
        end

endmodule

`default_nettype wire

//--- bench/sdram_tb.sv
/*
 * SDRAM controller testbench
 * random reads and writes over a small address pool, checked
 * against a reference memory, plus pin checks of the init
 * sequence, chip addressing and refresh spacing
 */
`default_nettype none

module sdram_tb;

    localparam int init_wait        = 20;
    localparam int refresh_interval = 60;
    localparam int refresh_wait     = 4;
    localparam int num_requests     = 200;
    localparam int pool_size        = 8;
    // reset, power-up wait, precharge, two refreshes, mode load
    localparam int init_cycles      = 3 + init_wait + 1 + 2 * refresh_wait + 2;
    localparam int cycle_limit      = init_cycles + 40 * num_requests;
    localparam int refresh_window   = refresh_interval + 40;

    logic                                   clk;
    logic                                   reset;
    logic                                   req;
    logic                                   we;
    logic [sdram_pkg::addr_width-1:0]       addr;
    logic [sdram_pkg::data_width-1:0]       data;
    wire                                    ack;
    wire                                    valid;
    wire  [sdram_pkg::data_width-1:0]       q;
    wire  [sdram_pkg::sdram_addr_width-1:0] sdram_a;
    wire  [sdram_pkg::bank_width-1:0]       sdram_ba;
    wire  [sdram_pkg::sdram_data_width-1:0] sdram_dq;
    wire                                    sdram_cke;
    wire                                    sdram_cs_n;
    wire                                    sdram_ras_n;
    wire                                    sdram_cas_n;
    wire                                    sdram_we_n;

    integer                             seed = 32'h0362_3401;
    int                                 errors = 0;
    int                                 cycles = 0;
    int                                 issued = 0;
    int                                 reads = 0;
    int                                 actives = 0;
    int                                 valids = 0;
    int                                 live_cycles = 0;
    int                                 init_step = 0;
    int                                 since_refresh = 0;
    bit                                 init_done = 1'b0;
    sdram_pkg::cmd_t                    init_seq [4];
    sdram_pkg::cmd_t                    pin_cmd;
    logic [sdram_pkg::addr_width-1:0]   pool [pool_size];
    logic [sdram_pkg::data_width-1:0]   ref_mem [logic [sdram_pkg::addr_width-1:0]];
    logic [sdram_pkg::data_width-1:0]   expected_q [$];
    logic [sdram_pkg::data_width-1:0]   exp_word;
    logic [sdram_pkg::addr_width-1:0]   active_addr = '0;
    logic [sdram_pkg::bank_width-1:0]   exp_bank;
    logic [sdram_pkg::row_width-1:0]    exp_row;
    logic [sdram_pkg::col_width-1:0]    exp_col;

    sdram_ctrl #(
        .init_wait        (init_wait),
        .refresh_interval (refresh_interval)
    ) i_dut (
        .clk, .reset, .req, .we, .addr, .data, .ack, .valid, .q,
        .sdram_a, .sdram_ba, .sdram_dq, .sdram_cke,
        .sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n
    );

    sdram_chip_model i_chip (
        .clk, .cke(sdram_cke), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n),
        .cas_n(sdram_cas_n), .we_n(sdram_we_n), .ba(sdram_ba), .a(sdram_a), .dq(sdram_dq)
    );

    bind sdram_ctrl sdram_props #(
        .active_wait         (active_wait),
        .write_recovery_wait (write_recovery_wait)
    ) i_props (
        .clk, .reset, .ack, .valid,
        .dq_oe (i_datapath.dq_oe),
        .cmd   ({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n})
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Error %s: expected %h, actual %h", test, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s at cycle %0d", what, cycles);
    endtask

    // new request, held until its ack
    task automatic issue_request();
        req  = 1'b1;
        we   = 1'($random(seed));
        addr = pool[$unsigned($random(seed)) % pool_size];
        data = $random(seed);
    endtask

    // ack shows one cycle after the accepting edge
    task automatic wait_for_ack();
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        active_addr = addr;
        issued++;
        if (we) begin
            ref_mem[addr] = data;
        end else begin
            reads++;
            expected_q.push_back(ref_mem.exists(addr) ? ref_mem[addr] : '0);
        end
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        data  = '0;
        init_seq = '{sdram_pkg::cmd_precharge, sdram_pkg::cmd_auto_refresh,
                     sdram_pkg::cmd_auto_refresh, sdram_pkg::cmd_load_mode};
        for (int i = 0; i < pool_size; i++) begin
            pool[i] = sdram_pkg::addr_width'($random(seed));
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // req stays high from one request to the next
        while (issued < num_requests) begin
            issue_request();
            wait_for_ack();
        end
        req = 1'b0;
        do begin
            @(posedge clk);
        end while (expected_q.size() != 0);

        assert (actives == issued) else report_mismatch("active_count", issued, actives);
        assert (valids == reads) else report_mismatch("valid_count", reads, valids);
        errors += i_dut.i_props.failures;
        $display("%0d errors (%0d from pin assertions) over %0d requests, %0d reads",
                 errors, i_dut.i_props.failures, issued, reads);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // pin monitor, mid-cycle when outputs are settled
    always @(negedge clk) begin
        if (!reset) begin
            pin_cmd = sdram_pkg::cmd_t'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});
            {exp_bank, exp_row, exp_col} = {active_addr, 1'b0};

            // cke low in the first cycle out of reset only
            assert (sdram_cke == (live_cycles != 0))
                else report_mismatch("cke", live_cycles != 0, sdram_cke);
            live_cycles++;

            // ack marks the cycle of the active command
            assert (ack == (pin_cmd == sdram_pkg::cmd_active))
                else report_mismatch("ack_active", pin_cmd == sdram_pkg::cmd_active, ack);
            if (pin_cmd == sdram_pkg::cmd_active) begin
                actives++;
            end

            if (!init_done) begin
                assert (!ack && !valid) else report_failure("ack or valid raised during init");
                if (pin_cmd != sdram_pkg::cmd_nop && pin_cmd != sdram_pkg::cmd_deselect) begin
                    assert (pin_cmd == init_seq[init_step])
                        else report_mismatch("init_sequence", init_seq[init_step], pin_cmd);
                    if (pin_cmd == sdram_pkg::cmd_precharge) begin
                        assert (sdram_a[10]) else report_failure("init precharge without A10");
                    end
                    if (pin_cmd == sdram_pkg::cmd_load_mode) begin
                        assert (sdram_a == sdram_pkg::mode_reg)
                            else report_mismatch("load_mode", sdram_pkg::mode_reg, sdram_a);
                    end
                    init_step++;
                    init_done = (init_step == 4);
                end
            end else begin
                since_refresh++;
                case (pin_cmd)
                    sdram_pkg::cmd_auto_refresh: since_refresh = 0;
                    sdram_pkg::cmd_active: begin
                        assert (sdram_ba == exp_bank)
                            else report_mismatch("active_bank", exp_bank, sdram_ba);
                        assert (sdram_a == exp_row)
                            else report_mismatch("active_row", exp_row, sdram_a);
                    end
                    sdram_pkg::cmd_read,
                    sdram_pkg::cmd_write: begin
                        assert (sdram_ba == exp_bank)
                            else report_mismatch("access_bank", exp_bank, sdram_ba);
                        assert (sdram_a[sdram_pkg::col_width-1:0] == exp_col)
                            else report_mismatch("access_col", exp_col, sdram_a);
                        assert (sdram_a[10]) else report_failure("column access without A10");
                    end
                    default: ;
                endcase
                assert (since_refresh < refresh_window)
                    else begin
                        report_failure("no auto refresh within the refresh window");
                        since_refresh = 0;
                    end
            end

            // read return in request order
            if (valid) begin
                valids++;
                assert (expected_q.size() != 0) else report_failure("valid without a pending read");
                if (expected_q.size() != 0) begin
                    exp_word = expected_q.pop_front();
                    assert (q == exp_word) else report_mismatch("read_data", exp_word, q);
                end
            end
        end
    end

    // watchdog
    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d requests acked",
                 cycles, issued, num_requests);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/sdram_ctrl.sv
/*
 * SDRAM controller top level
 * 32-bit req/ack word interface onto a 16Mx16 SDRAM,
 * wait counts given in cycles, defaults for a 60 MHz clock
 */
`default_nettype none

module sdram_ctrl #(
    parameter int init_wait           = 12000,
    parameter int precharge_wait      = 1,
    parameter int load_mode_wait      = 1,
    parameter int active_wait         = 1,
    parameter int refresh_wait        = 4,
    parameter int write_recovery_wait = 2,
    parameter int refresh_interval    = 458
) (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire                                     req,
    input  wire                                     we,
    input  wire  [sdram_pkg::addr_width-1:0]        addr,
    input  wire  [sdram_pkg::data_width-1:0]        data,
    output logic                                    ack,
    output logic                                    valid,
    output logic [sdram_pkg::data_width-1:0]        q,
    output logic [sdram_pkg::sdram_addr_width-1:0]  sdram_a,
    output logic [sdram_pkg::bank_width-1:0]        sdram_ba,
    inout  wire  [sdram_pkg::sdram_data_width-1:0]  sdram_dq,
    output logic                                    sdram_cke,
    output logic                                    sdram_cs_n,
    output logic                                    sdram_ras_n,
    output logic                                    sdram_cas_n,
    output logic                                    sdram_we_n
);

    sdram_pkg::state_t                  state;
    sdram_pkg::state_t                  next_state;
    sdram_pkg::cmd_t                    cmd;
    sdram_pkg::wait_flags_t             wait_flags;
    sdram_pkg::host_req_t               host;
    sdram_pkg::sdram_a_u                a;
    sdram_pkg::sdram_bus_t              bus;
    logic [sdram_pkg::wait_width-1:0]   wait_count;
    logic [sdram_pkg::bank_width-1:0]   ba;
    logic                               should_refresh;
    logic                               we_latched;
    logic                               start;
    logic                               cke;

    assign host = '{addr: addr, data: data, we: we};

    sdram_timer #(
        .load_mode_wait      (load_mode_wait),
        .active_wait         (active_wait),
        .refresh_wait        (refresh_wait),
        .write_recovery_wait (write_recovery_wait),
        .refresh_interval    (refresh_interval)
    ) i_timer (
        .clk, .reset, .state, .next_state, .wait_count, .wait_flags, .should_refresh
    );

    sdram_sequencer #(
        .init_wait      (init_wait),
        .precharge_wait (precharge_wait),
        .refresh_wait   (refresh_wait)
    ) i_sequencer (
        .clk, .reset, .req, .we_latched, .wait_count, .wait_flags, .should_refresh,
        .state, .next_state, .cmd, .cke, .start, .ack
    );

    sdram_datapath i_datapath (
        .clk, .state, .start, .host, .wait_count, .wait_flags,
        .we_latched, .ba, .a, .dq(sdram_dq), .q, .valid
    );

    // chip pins
    assign bus = '{cke: cke, cmd: cmd, ba: ba, a: a};

    assign sdram_cke = bus.cke;
    assign sdram_ba  = bus.ba;
    assign sdram_a   = bus.a;
    assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = bus.cmd;

endmodule

`default_nettype wire

//--- rtl/sdram_datapath.sv
/*
 * SDRAM datapath
 * latches the host request, splits the word address into
 * bank / row / column, drives the chip address and data bus,
 * and assembles the read word from its two beats
 */
`default_nettype none

module sdram_datapath (
    input  wire                                     clk,
    input  sdram_pkg::state_t                       state,
    input  wire                                     start,
    input  sdram_pkg::host_req_t                    host,
    input  wire  [sdram_pkg::wait_width-1:0]        wait_count,
    input  sdram_pkg::wait_flags_t                  wait_flags,
    output logic                                    we_latched,
    output logic [sdram_pkg::bank_width-1:0]        ba,
    output sdram_pkg::sdram_a_u                     a,
    inout  wire  [sdram_pkg::sdram_data_width-1:0]  dq,
    output logic [sdram_pkg::data_width-1:0]        q,
    output logic                                    valid
);

    localparam int beat = sdram_pkg::sdram_data_width;
    localparam int chip_addr_width =
        sdram_pkg::bank_width + sdram_pkg::row_width + sdram_pkg::col_width;

    logic [chip_addr_width-1:0]          addr_reg;
    logic [sdram_pkg::data_width-1:0]    data_reg;
    logic [sdram_pkg::col_width-1:0]     col;
    logic [sdram_pkg::row_width-1:0]     row;
    logic [sdram_pkg::bank_width-1:0]    bank;
    logic [beat-1:0]                     dq_out;
    logic                                dq_oe;

    // word address to 16-bit beat address, i.e. times two
    always_ff @(posedge clk) begin
        if (start) begin
            addr_reg   <= {host.addr, 1'b0};
            data_reg   <= host.data;
            we_latched <= host.we;
        end
    end

    // {bank, row, col}
    assign col  = addr_reg[sdram_pkg::col_width-1:0];
    assign row  = addr_reg[sdram_pkg::col_width +: sdram_pkg::row_width];
    assign bank = addr_reg[chip_addr_width-1 -: sdram_pkg::bank_width];

    always_comb begin
        case (state)
            sdram_pkg::st_active,
            sdram_pkg::st_read,
            sdram_pkg::st_write: ba = bank;
            default:             ba = '0;
        endcase
    end

    always_comb begin
        a = '0;
        case (state)
            // A10 high, precharge hits all banks
            sdram_pkg::st_init:   a.access.auto_precharge = 1'b1;
            sdram_pkg::st_mode:   a = sdram_pkg::mode_reg;
            sdram_pkg::st_active: a = sdram_pkg::sdram_a_u'(row);
            sdram_pkg::st_read,
            sdram_pkg::st_write: begin
                // column access closes the row itself
                a.access.auto_precharge = 1'b1;
                a.access.col            = col;
            end
            default: ;
        endcase
    end

    // write beats, high half first
    assign dq_oe  = (state == sdram_pkg::st_write);
    assign dq_out = (wait_count == '0) ? data_reg[2*beat-1 -: beat] : data_reg[beat-1:0];
    assign dq     = dq_oe ? dq_out : 'z;

    // read beats, high half first, valid after the low half
    always_ff @(posedge clk) begin
        valid <= 1'b0;
        if (state == sdram_pkg::st_read) begin
            if (wait_flags.first_word) begin
                q[2*beat-1 -: beat] <= dq;
            end else if (wait_flags.read_done) begin
                q[beat-1:0] <= dq;
                valid       <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/sdram_pkg.sv
/*
 * SDRAM controller shared definitions
 * bus widths, fixed burst/CAS settings, chip command codes,
 * controller states and the structs passed between blocks
 */
`default_nettype none

package sdram_pkg;

    // host side word interface
    localparam int addr_width = 23;
    localparam int data_width = 32;

    // chip side, 16Mx16 part
    localparam int sdram_addr_width = 13;
    localparam int sdram_data_width = 16;
    localparam int col_width        = 9;
    localparam int row_width        = 13;
    localparam int bank_width       = 2;

    // fixed access shape, one 32-bit word = two 16-bit beats
    localparam int cas_latency  = 2;
    localparam int burst_length = 2;

    // width of the per-state cycle counter
    localparam int wait_width = 14;

    typedef enum logic [2:0] {
        st_init,
        st_mode,
        st_idle,
        st_active,
        st_read,
        st_write,
        st_refresh
    } state_t;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        cmd_deselect     = 4'b1111,
        cmd_load_mode    = 4'b0000,
        cmd_auto_refresh = 4'b0001,
        cmd_precharge    = 4'b0010,
        cmd_active       = 4'b0011,
        cmd_write        = 4'b0100,
        cmd_read         = 4'b0101,
        cmd_nop          = 4'b0111
    } cmd_t;

    // captured host request
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic                  we;
    } host_req_t;

    typedef struct packed {
        logic load_mode_done;
        logic active_done;
        logic refresh_done;
        logic first_word;
        logic read_done;
        logic write_done;
    } wait_flags_t;

    // chip address pins, mode register view or column access view
    typedef union packed {
        struct packed {
            logic [2:0] reserved;
            logic       write_burst_single;
            logic [1:0] op_mode;
            logic [2:0] cas;
            logic       interleaved;
            logic [2:0] burst_len_log2;
        } mode;
        struct packed {
            logic [1:0]           upper;
            logic                 auto_precharge;
            logic                 spare;
            logic [col_width-1:0] col;
        } access;
    } sdram_a_u;

    // sequential bursts, burst writes, CAS 2, two beats
    localparam sdram_a_u mode_reg = sdram_a_u'({
        3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'($clog2(burst_length))
    });

    // chip control outputs
    typedef struct packed {
        logic                  cke;
        cmd_t                  cmd;
        logic [bank_width-1:0] ba;
        sdram_a_u              a;
    } sdram_bus_t;

endpackage

`default_nettype wire

//--- rtl/sdram_sequencer.sv
/*
 * SDRAM command sequencer
 * runs the power-up sequence, then the idle / active / read / write /
 * refresh loop, and registers the chip command for each transition
 * along with the next state
 */
`default_nettype none

module sdram_sequencer #(
    parameter int init_wait      = 12000,
    parameter int precharge_wait = 1,
    parameter int refresh_wait   = 4
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 req,
    input  wire                                 we_latched,
    input  wire  [sdram_pkg::wait_width-1:0]    wait_count,
    input  sdram_pkg::wait_flags_t              wait_flags,
    input  wire                                 should_refresh,
    output sdram_pkg::state_t                   state,
    output sdram_pkg::state_t                   next_state,
    output sdram_pkg::cmd_t                     cmd,
    output logic                                cke,
    output logic                                start,
    output logic                                ack
);

    // power-up command points, in cycles from reset
    localparam int precharge_at = init_wait - 1;
    localparam int refresh1_at  = init_wait + precharge_wait - 1;
    localparam int refresh2_at  = refresh1_at + refresh_wait;
    localparam int load_mode_at = refresh2_at + refresh_wait;

    sdram_pkg::cmd_t next_cmd;

    // decision point, a new request may start here
    always_comb begin
        case (state)
            sdram_pkg::st_idle:    start = 1'b1;
            sdram_pkg::st_read:    start = wait_flags.read_done;
            sdram_pkg::st_write:   start = wait_flags.write_done;
            sdram_pkg::st_refresh: start = wait_flags.refresh_done;
            default:               start = 1'b0;
        endcase
    end

    always_comb begin
        next_state = state;
        next_cmd   = sdram_pkg::cmd_nop;

        case (state)
            sdram_pkg::st_init: begin
                if (wait_count == '0) begin
                    next_cmd = sdram_pkg::cmd_deselect;
                end else if (wait_count == precharge_at) begin
                    // precharge all, A10 set by the datapath
                    next_cmd = sdram_pkg::cmd_precharge;
                end else if (wait_count == refresh1_at || wait_count == refresh2_at) begin
                    next_cmd = sdram_pkg::cmd_auto_refresh;
                end else if (wait_count == load_mode_at) begin
                    next_state = sdram_pkg::st_mode;
                    next_cmd   = sdram_pkg::cmd_load_mode;
                end
            end

            // wait out tMRD
            sdram_pkg::st_mode: begin
                if (wait_flags.load_mode_done) begin
                    next_state = sdram_pkg::st_idle;
                end
            end

            // row open, go to column access after tRCD
            sdram_pkg::st_active: begin
                if (wait_flags.active_done) begin
                    if (we_latched) begin
                        next_state = sdram_pkg::st_write;
                        next_cmd   = sdram_pkg::cmd_write;
                    end else begin
                        next_state = sdram_pkg::st_read;
                        next_cmd   = sdram_pkg::cmd_read;
                    end
                end
            end

            // refresh beats a pending request
            sdram_pkg::st_idle,
            sdram_pkg::st_read,
            sdram_pkg::st_write,
            sdram_pkg::st_refresh: begin
                if (start) begin
                    if (should_refresh) begin
                        next_state = sdram_pkg::st_refresh;
                        next_cmd   = sdram_pkg::cmd_auto_refresh;
                    end else if (req) begin
                        next_state = sdram_pkg::st_active;
                        next_cmd   = sdram_pkg::cmd_active;
                    end else begin
                        next_state = sdram_pkg::st_idle;
                    end
                end
            end

            // unused encoding
            default: begin
                next_state = sdram_pkg::st_init;
            end
        endcase
    end

    // command goes out together with its state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= sdram_pkg::st_init;
            cmd   <= sdram_pkg::cmd_nop;
        end else begin
            state <= next_state;
            cmd   <= next_cmd;
        end
    end

    // request accepted, first cycle of active
    assign ack = (state == sdram_pkg::st_active) && (wait_count == '0);

    // clock enable low in the very first init cycle only
    assign cke = !((state == sdram_pkg::st_init) && (wait_count == '0));

endmodule

`default_nettype wire

//--- rtl/sdram_timer.sv
/*
 * SDRAM wait timer
 * counts cycles spent in the current state, runs the refresh
 * interval counter and decodes the per-state done flags
 */
`default_nettype none

module sdram_timer #(
    parameter int load_mode_wait      = 1,
    parameter int active_wait         = 1,
    parameter int refresh_wait        = 4,
    parameter int write_recovery_wait = 2,
    parameter int refresh_interval    = 458
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  sdram_pkg::state_t                   state,
    input  sdram_pkg::state_t                   next_state,
    output logic [sdram_pkg::wait_width-1:0]    wait_count,
    output sdram_pkg::wait_flags_t              wait_flags,
    output logic                                should_refresh
);

    localparam int read_wait     = sdram_pkg::cas_latency + sdram_pkg::burst_length;
    localparam int write_wait    = sdram_pkg::burst_length + write_recovery_wait;
    localparam int refresh_width = $clog2(refresh_interval + 1);

    logic [refresh_width-1:0] refresh_count;

    // restarts on every state change
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_count <= '0;
        end else if (state != next_state) begin
            wait_count <= '0;
        end else begin
            wait_count <= wait_count + 1'b1;
        end
    end

    // restart at first refresh cycle, hold once the interval is up
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            refresh_count <= '0;
        end else if (state == sdram_pkg::st_refresh && wait_count == '0) begin
            refresh_count <= '0;
        end else if (!should_refresh) begin
            refresh_count <= refresh_count + 1'b1;
        end
    end

    assign should_refresh = (refresh_count >= refresh_interval - 1);

    // last cycle of each timed state
    assign wait_flags.load_mode_done = (wait_count == load_mode_wait - 1);
    assign wait_flags.active_done    = (wait_count == active_wait - 1);
    assign wait_flags.refresh_done   = (wait_count == refresh_wait - 1);
    // high beat arrives cas_latency after the read command
    assign wait_flags.first_word     = (wait_count == sdram_pkg::cas_latency);
    assign wait_flags.read_done      = (wait_count == read_wait - 1);
    assign wait_flags.write_done     = (wait_count == write_wait - 1);

endmodule

`default_nettype wire
